// ==== hdl/mem_pkg.sv ====
// memory subsystem definitions
// cpu and halfword bus structs, access size codes and store sizing

package mem_pkg;

  // --------------------
  // sizes
  localparam int addr_w        = 12;
  localparam int hw_addr_w     = addr_w - 1;
  localparam int store_depth   = 2048;
  localparam int store_latency = 3;
  localparam int lat_cnt_w     = $clog2(store_latency + 1);

  typedef logic [lat_cnt_w-1:0] lat_cnt_t;

  // counter load value, done fires as the count leaves 1
  localparam lat_cnt_t lat_cnt_load = lat_cnt_t'(store_latency - 1);

  // --------------------
  // access size, bit 1 set means word
  typedef logic [1:0] size_t;

  localparam size_t size_byte = 2'b00;
  localparam size_t size_half = 2'b01;
  localparam size_t size_word = 2'b10;

  // --------------------
  // cpu side
  typedef struct packed {
    logic              en;
    logic              wr;
    size_t             size;
    logic [addr_w-1:0] addr;
    logic [31:0]       wdata;
  } cpu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        wt;
  } cpu_rsp_t;

  // halfword side
  typedef struct packed {
    logic                 rd;
    logic                 wr;
    logic [hw_addr_w-1:0] addr;
    logic [15:0]          wdata;
  } hw_req_t;

  typedef struct packed {
    logic        done;
    logic [15:0] rdata;
  } hw_rsp_t;

endpackage

// ==== hdl/ram_sizer.sv ====
`timescale 1ns/1ps
// ram sizer
// breaks one word, halfword or byte access into 16-bit halfword transfers

module ram_sizer (
  input  logic              clk,
  input  logic              reset,
  input  mem_pkg::cpu_req_t cpu_req,
  input  mem_pkg::hw_rsp_t  hw_rsp,
  output mem_pkg::cpu_rsp_t cpu_rsp,
  output mem_pkg::hw_req_t  hw_req,
  output logic              hold
);

  typedef enum logic [3:0] {
    st_idle      = 4'b0000,
    st_wr_word_u = 4'b0001,
    st_wr_word_l = 4'b0010,
    st_rd_word_u = 4'b0011,
    st_rd_word_l = 4'b0100,
    st_wr_half   = 4'b0101,
    st_rd_half   = 4'b0110,
    st_rmw_rd    = 4'b0111,
    st_rmw_wr    = 4'b1000,
    st_rd_byte   = 4'b1001,
    st_end       = 4'b1111
  } state_t;

  state_t      state;
  logic        wt_q;
  logic [31:0] rdata_q;
  // upper half of a word read, or old halfword of a byte write
  logic [15:0] hw_buf;

  logic        done;
  logic        a0;
  logic        xfer_rd;
  logic        xfer_wr;
  logic [15:0] xfer_wdata;

  assign done = hw_rsp.done;
  assign hold = (state != st_idle);

  assign cpu_rsp = '{rdata: rdata_q, wt: wt_q};

  // request is dropped in the done cycle
  assign hw_req = '{
    rd:    xfer_rd & ~done,
    wr:    xfer_wr & ~done,
    addr:  {cpu_req.addr[mem_pkg::addr_w-1:2], a0},
    wdata: xfer_wdata
  };

  // --------------------
  // state machine
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      wt_q  <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          if (cpu_req.en) begin
            if (|(cpu_req.size & mem_pkg::size_word)) begin
              state <= cpu_req.wr ? st_wr_word_u : st_rd_word_u;
            end else if (cpu_req.size == mem_pkg::size_half) begin
              state <= cpu_req.wr ? st_wr_half : st_rd_half;
            end else if (cpu_req.size == mem_pkg::size_byte) begin
              state <= cpu_req.wr ? st_rmw_rd : st_rd_byte;
            end
          end
        end
        st_wr_word_u: begin
          if (done) begin
            state <= st_wr_word_l;
          end
        end
        st_rd_word_u: begin
          if (done) begin
            state <= st_rd_word_l;
          end
        end
        st_rmw_rd: begin
          if (done) begin
            state <= st_rmw_wr;
          end
        end
        // last transfer of every access
        st_wr_word_l, st_rd_word_l, st_wr_half, st_rd_half,
        st_rmw_wr, st_rd_byte: begin
          if (done) begin
            state <= st_end;
            wt_q  <= 1'b0;
          end
        end
        st_end: begin
          state <= st_idle;
          wt_q  <= 1'b1;
        end
        default: begin
          state <= st_idle;
          wt_q  <= 1'b1;
        end
      endcase
    end
  end

  // --------------------
  // read data capture
  always_ff @(posedge clk) begin
    if (done) begin
      case (state)
        st_rd_word_u, st_rmw_rd: begin
          hw_buf <= hw_rsp.rdata;
        end
        st_rd_word_l: begin
          rdata_q <= {hw_buf, hw_rsp.rdata};
        end
        st_rd_half: begin
          rdata_q <= {16'h0000, hw_rsp.rdata};
        end
        st_rd_byte: begin
          // addr bit 0 clear picks the high byte
          if (cpu_req.addr[0]) begin
            rdata_q <= {24'h000000, hw_rsp.rdata[7:0]};
          end else begin
            rdata_q <= {24'h000000, hw_rsp.rdata[15:8]};
          end
        end
        default: begin
        end
      endcase
    end
  end

  // --------------------
  // halfword transfer per state
  always_comb begin
    a0         = cpu_req.addr[1];
    xfer_rd    = 1'b0;
    xfer_wr    = 1'b0;
    xfer_wdata = cpu_req.wdata[15:0];
    case (state)
      st_wr_word_u: begin
        a0         = 1'b0;
        xfer_wr    = 1'b1;
        xfer_wdata = cpu_req.wdata[31:16];
      end
      st_wr_word_l: begin
        a0      = 1'b1;
        xfer_wr = 1'b1;
      end
      st_rd_word_u: begin
        a0      = 1'b0;
        xfer_rd = 1'b1;
      end
      st_rd_word_l: begin
        a0      = 1'b1;
        xfer_rd = 1'b1;
      end
      st_wr_half: begin
        xfer_wr = 1'b1;
      end
      st_rd_half, st_rmw_rd, st_rd_byte: begin
        xfer_rd = 1'b1;
      end
      st_rmw_wr: begin
        xfer_wr = 1'b1;
        // new byte merged into the halfword read before
        if (cpu_req.addr[0]) begin
          xfer_wdata = {hw_buf[15:8], cpu_req.wdata[7:0]};
        end else begin
          xfer_wdata = {cpu_req.wdata[7:0], hw_buf[7:0]};
        end
      end
      default: begin
      end
    endcase
  end

  // completion is a single cycle pulse
  wt_single_low : assert property (
    @(posedge clk) disable iff (reset)
    !cpu_rsp.wt |=> cpu_rsp.wt
  );

endmodule

// ==== hdl/halfword_arbiter.sv ====
`timescale 1ns/1ps
// halfword arbiter
// round-robin between two sizers, grant held for a whole cpu access

module halfword_arbiter (
  input  logic             clk,
  input  logic             reset,
  input  mem_pkg::hw_req_t req_a,
  input  mem_pkg::hw_req_t req_b,
  input  logic             hold_a,
  input  logic             hold_b,
  input  mem_pkg::hw_rsp_t store_rsp,
  output mem_pkg::hw_rsp_t rsp_a,
  output mem_pkg::hw_rsp_t rsp_b,
  output mem_pkg::hw_req_t store_req
);

  // one-hot grant, bit 0 is port a
  logic [1:0] grant;
  logic       last_b;

  logic       act_a;
  logic       act_b;
  logic       owner_hold;
  logic       pick_b;

  assign act_a = req_a.rd | req_a.wr;
  assign act_b = req_b.rd | req_b.wr;

  assign owner_hold = (grant[0] & hold_a) | (grant[1] & hold_b);

  // alternate only when both ask
  always_comb begin
    if (act_a && act_b) begin
      pick_b = ~last_b;
    end else begin
      pick_b = act_b;
    end
  end

  // --------------------
  // grant register
  always_ff @(posedge clk) begin
    if (reset) begin
      grant  <= 2'b00;
      last_b <= 1'b0;
    end else if (!owner_hold) begin
      if (act_a || act_b) begin
        grant  <= pick_b ? 2'b10 : 2'b01;
        last_b <= pick_b;
      end else begin
        grant <= 2'b00;
      end
    end
  end

  // --------------------
  // routing
  always_comb begin
    if (grant[1]) begin
      store_req = req_b;
    end else if (grant[0]) begin
      store_req = req_a;
    end else begin
      store_req = '0;
    end
  end

  assign rsp_a = '{done: grant[0] & store_rsp.done, rdata: store_rsp.rdata};
  assign rsp_b = '{done: grant[1] & store_rsp.done, rdata: store_rsp.rdata};

  // keeps a byte read-modify-write in one piece
  grant_locked : assert property (
    @(posedge clk) disable iff (reset)
    owner_hold |=> (grant == $past(grant))
  );

endmodule

// ==== hdl/halfword_store.sv ====
`timescale 1ns/1ps
// halfword store
// on-chip halfword memory, done pulse a fixed number of cycles after a request

module halfword_store (
  input  logic             clk,
  input  logic             reset,
  input  mem_pkg::hw_req_t req,
  output mem_pkg::hw_rsp_t rsp
);

  logic [15:0] mem [mem_pkg::store_depth];

  logic              busy;
  mem_pkg::lat_cnt_t cnt;
  logic              done_q;
  logic [15:0]       rdata_q;
  logic              accept;

  // requests held during the busy time are ignored
  assign accept = ~busy & (req.rd | req.wr);

  assign rsp = '{done: done_q, rdata: rdata_q};

  // --------------------
  // latency counter
  always_ff @(posedge clk) begin
    if (reset) begin
      busy   <= 1'b0;
      cnt    <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
        cnt  <= mem_pkg::lat_cnt_load;
      end else if (busy) begin
        if (cnt == mem_pkg::lat_cnt_t'(1)) begin
          busy   <= 1'b0;
          done_q <= 1'b1;
        end
        cnt <= cnt - mem_pkg::lat_cnt_t'(1);
      end
    end
  end

  // --------------------
  // array access at acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      if (req.wr) begin
        mem[req.addr] <= req.wdata;
      end else begin
        rdata_q <= mem[req.addr];
      end
    end
  end

  // sizer and arbiter together must never merge a read and a write
  rd_wr_exclusive : assert property (
    @(posedge clk) disable iff (reset)
    !(req.rd && req.wr)
  );

endmodule

// ==== hdl/mem_subsystem.sv ====
`timescale 1ns/1ps
// memory subsystem top
// two cpu ports sized to halfwords, sharing one store through an arbiter

module mem_subsystem (
  input  logic              clk,
  input  logic              reset,
  input  mem_pkg::cpu_req_t cpu_req_a,
  input  mem_pkg::cpu_req_t cpu_req_b,
  output mem_pkg::cpu_rsp_t cpu_rsp_a,
  output mem_pkg::cpu_rsp_t cpu_rsp_b
);

  mem_pkg::hw_req_t hw_req_a;
  mem_pkg::hw_req_t hw_req_b;
  mem_pkg::hw_rsp_t hw_rsp_a;
  mem_pkg::hw_rsp_t hw_rsp_b;
  mem_pkg::hw_req_t store_req;
  mem_pkg::hw_rsp_t store_rsp;
  logic             hold_a;
  logic             hold_b;

  // --------------------
  // cpu ports
  ram_sizer i_sizer_a (
    .clk     (clk),
    .reset   (reset),
    .cpu_req (cpu_req_a),
    .hw_rsp  (hw_rsp_a),
    .cpu_rsp (cpu_rsp_a),
    .hw_req  (hw_req_a),
    .hold    (hold_a)
  );

  ram_sizer i_sizer_b (
    .clk     (clk),
    .reset   (reset),
    .cpu_req (cpu_req_b),
    .hw_rsp  (hw_rsp_b),
    .cpu_rsp (cpu_rsp_b),
    .hw_req  (hw_req_b),
    .hold    (hold_b)
  );

  // --------------------
  // shared halfword path
  halfword_arbiter i_arbiter (
    .clk       (clk),
    .reset     (reset),
    .req_a     (hw_req_a),
    .req_b     (hw_req_b),
    .hold_a    (hold_a),
    .hold_b    (hold_b),
    .store_rsp (store_rsp),
    .rsp_a     (hw_rsp_a),
    .rsp_b     (hw_rsp_b),
    .store_req (store_req)
  );

  halfword_store i_store (
    .clk   (clk),
    .reset (reset),
    .req   (store_req),
    .rsp   (store_rsp)
  );

endmodule

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
// memory subsystem testbench
// two cpu ports against a byte shadow model, read data checked by assertions

module tb_mem_subsystem;

  typedef logic [mem_pkg::addr_w-1:0] addr_t;

  localparam int    timeout_cycles = 200;
  localparam addr_t region_a       = 12'h400;
  localparam addr_t region_b       = 12'h480;

  logic              clk;
  logic              reset;
  mem_pkg::cpu_req_t req_a;
  mem_pkg::cpu_req_t req_b;
  mem_pkg::cpu_rsp_t rsp_a;
  mem_pkg::cpu_rsp_t rsp_b;

  logic [31:0] exp_a;
  logic [31:0] exp_b;
  logic        chk_a;
  logic        chk_b;
  logic [2:0]  settle_cnt;
  // big-endian byte image of the store
  logic [7:0]  shadow [0:(1 << mem_pkg::addr_w) - 1];
  integer      seed = 32'hb174;

  mem_subsystem i_dut (
    .clk       (clk),
    .reset     (reset),
    .cpu_req_a (req_a),
    .cpu_req_b (req_b),
    .cpu_rsp_a (rsp_a),
    .cpu_rsp_b (rsp_b)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // checks
  always @(posedge clk) begin
    if (reset) begin
      settle_cnt <= 3'd4;
    end else if (settle_cnt != 3'd0) begin
      settle_cnt <= settle_cnt - 3'd1;
    end
  end

  wt_idle_after_reset : assert property (
    @(posedge clk) (!reset && settle_cnt != 3'd0) |-> (rsp_a.wt && rsp_b.wt)
  ) else begin
    $display("MISMATCH at %0t: wt not high on both ports after reset", $time);
    $display("TB FAILED");
    $fatal(1, "wt after reset");
  end

  read_a_matches : assert property (
    @(posedge clk) disable iff (reset)
    (!rsp_a.wt && chk_a) |-> (rsp_a.rdata == exp_a)
  ) else begin
    $display("MISMATCH at %0t: port a read gave %h, expected %h",
             $time, $sampled(rsp_a.rdata), $sampled(exp_a));
    $display("TB FAILED");
    $fatal(1, "port a read data");
  end

  read_b_matches : assert property (
    @(posedge clk) disable iff (reset)
    (!rsp_b.wt && chk_b) |-> (rsp_b.rdata == exp_b)
  ) else begin
    $display("MISMATCH at %0t: port b read gave %h, expected %h",
             $time, $sampled(rsp_b.rdata), $sampled(exp_b));
    $display("TB FAILED");
    $fatal(1, "port b read data");
  end

  // --------------------
  // shadow model
  function automatic logic [31:0] model_read(input mem_pkg::size_t size, input addr_t addr);
    addr_t       base;
    logic [31:0] value;
    if (size[1]) begin
      base  = addr & ~addr_t'(3);
      value = {shadow[base], shadow[base + addr_t'(1)],
               shadow[base + addr_t'(2)], shadow[base + addr_t'(3)]};
    end else if (size[0]) begin
      base  = addr & ~addr_t'(1);
      value = {16'h0000, shadow[base], shadow[base + addr_t'(1)]};
    end else begin
      value = {24'h000000, shadow[addr]};
    end
    return value;
  endfunction

  function automatic void model_write(input mem_pkg::size_t size, input addr_t addr,
                                      input logic [31:0] data);
    addr_t base;
    if (size[1]) begin
      base                      = addr & ~addr_t'(3);
      shadow[base]              = data[31:24];
      shadow[base + addr_t'(1)] = data[23:16];
      shadow[base + addr_t'(2)] = data[15:8];
      shadow[base + addr_t'(3)] = data[7:0];
    end else if (size[0]) begin
      base                      = addr & ~addr_t'(1);
      shadow[base]              = data[15:8];
      shadow[base + addr_t'(1)] = data[7:0];
    end else begin
      shadow[addr] = data[7:0];
    end
  endfunction

  function automatic logic [31:0] fill_word(input addr_t addr);
    return {4'ha, addr, 4'h5, ~addr};
  endfunction

  function automatic mem_pkg::cpu_req_t make_req(input logic wr, input mem_pkg::size_t size,
                                                 input addr_t addr, input logic [31:0] data);
    mem_pkg::cpu_req_t req;
    req = '{en: 1'b1, wr: wr, size: size, addr: addr, wdata: data};
    return req;
  endfunction

  // --------------------
  // stimulus
  task automatic run_pair(input logic use_a, input mem_pkg::cpu_req_t ra,
                          input logic use_b, input mem_pkg::cpu_req_t rb);
    logic busy_a;
    logic busy_b;
    int   cycles;
    busy_a = use_a;
    busy_b = use_b;
    cycles = 0;
    @(posedge clk);
    if (use_a) begin
      req_a <= ra;
      chk_a <= ~ra.wr;
      exp_a <= model_read(ra.size, ra.addr);
    end
    if (use_b) begin
      req_b <= rb;
      chk_b <= ~rb.wr;
      exp_b <= model_read(rb.size, rb.addr);
    end
    // writes land in the model after the expected reads are taken
    if (use_a && ra.wr) begin
      model_write(ra.size, ra.addr, ra.wdata);
    end
    if (use_b && rb.wr) begin
      model_write(rb.size, rb.addr, rb.wdata);
    end
    while ((busy_a || busy_b) && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
      if (busy_a && !rsp_a.wt) begin
        busy_a = 1'b0;
        req_a <= '0;
      end
      if (busy_b && !rsp_b.wt) begin
        busy_b = 1'b0;
        req_b <= '0;
      end
    end
    if (busy_a || busy_b) begin
      $display("timeout after %0d cycles waiting for wt low (port a busy %0b, port b busy %0b)",
               cycles, busy_a, busy_b);
      $display("TB FAILED");
      $fatal(1, "access timeout");
    end
  endtask

  task automatic access_a(input logic wr, input mem_pkg::size_t size, input addr_t addr,
                          input logic [31:0] data);
    run_pair(1'b1, make_req(wr, size, addr, data), 1'b0, '0);
  endtask

  task automatic access_b(input logic wr, input mem_pkg::size_t size, input addr_t addr,
                          input logic [31:0] data);
    run_pair(1'b0, '0, 1'b1, make_req(wr, size, addr, data));
  endtask

  // aligned random access inside a 128 byte region
  task automatic random_access(input addr_t region, output mem_pkg::cpu_req_t req);
    logic [31:0]    r;
    addr_t          addr;
    mem_pkg::size_t size;
    r    = $random(seed);
    size = r[8:7];
    addr = region | addr_t'(r[6:0]);
    if (size[1]) begin
      addr = addr & ~addr_t'(3);
    end else if (size[0]) begin
      addr = addr & ~addr_t'(1);
    end
    req = make_req(r[9], size, addr, $random(seed));
  endtask

  initial begin
    logic [31:0]       word;
    mem_pkg::cpu_req_t ra;
    mem_pkg::cpu_req_t rb;
    reset = 1'b1;
    req_a = '0;
    req_b = '0;
    exp_a = '0;
    exp_b = '0;
    chk_a = 1'b0;
    chk_b = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);

    // word round trip, then its halves
    word = $random(seed);
    access_a(1'b1, mem_pkg::size_word, 12'h010, word);
    access_a(1'b0, mem_pkg::size_word, 12'h010, '0);
    access_a(1'b0, 2'b11, 12'h010, '0);
    access_a(1'b0, mem_pkg::size_half, 12'h010, '0);
    access_a(1'b0, mem_pkg::size_half, 12'h012, '0);

    // halfword and both of its bytes
    word = $random(seed);
    access_a(1'b1, mem_pkg::size_half, 12'h020, word);
    access_a(1'b0, mem_pkg::size_half, 12'h020, '0);
    access_a(1'b0, mem_pkg::size_byte, 12'h020, '0);
    access_a(1'b0, mem_pkg::size_byte, 12'h021, '0);

    // byte writes keep their neighbours
    access_a(1'b1, mem_pkg::size_word, 12'h030, fill_word(12'h030));
    word = $random(seed);
    access_a(1'b1, mem_pkg::size_byte, 12'h031, word);
    access_a(1'b0, mem_pkg::size_word, 12'h030, '0);
    access_a(1'b1, mem_pkg::size_byte, 12'h032, {24'h000000, word[15:8]});
    access_b(1'b0, mem_pkg::size_word, 12'h030, '0);
    access_b(1'b0, mem_pkg::size_byte, 12'h033, '0);

    // --------------------
    // both ports at once, separate regions
    for (int i = 0; i < 32; i++) begin
      run_pair(1'b1, make_req(1'b1, mem_pkg::size_word, region_a + addr_t'(4 * i),
                              fill_word(region_a + addr_t'(4 * i))),
               1'b1, make_req(1'b1, mem_pkg::size_word, region_b + addr_t'(4 * i),
                              fill_word(region_b + addr_t'(4 * i))));
    end
    for (int i = 0; i < 48; i++) begin
      random_access(region_a, ra);
      random_access(region_b, rb);
      run_pair(1'b1, ra, 1'b1, rb);
    end

    // colliding byte writes into one halfword
    access_a(1'b1, mem_pkg::size_word, 12'h200, fill_word(12'h200));
    word = $random(seed);
    run_pair(1'b1, make_req(1'b1, mem_pkg::size_byte, 12'h200, word),
             1'b1, make_req(1'b1, mem_pkg::size_byte, 12'h201, {24'h0, word[15:8]}));
    access_a(1'b0, mem_pkg::size_word, 12'h200, '0);
    run_pair(1'b1, make_req(1'b1, mem_pkg::size_byte, 12'h203, {24'h0, word[23:16]}),
             1'b1, make_req(1'b1, mem_pkg::size_byte, 12'h202, {24'h0, word[31:24]}));
    access_b(1'b0, mem_pkg::size_word, 12'h200, '0);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/mem_pkg.sv
hdl/ram_sizer.sv
hdl/halfword_arbiter.sv
hdl/halfword_store.sv
hdl/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_mem_subsystem \
  -f filelist.f \
  -o sim_tb

# the log decides the result, a fatal stop leaves no pass line in it
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported failure"
  exit 1
fi
